// ==== Makefile ====
TOP = tb_area_scan

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f area_scan_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f area_scan_top.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== area_scan_chk.sv ====
`timescale 1ns/10ps
// ========================================
// scan engine protocol checks
// status pulses, FRAM strobes, result writes
// ========================================
module area_scan_chk (
	input logic clk,
	input logic rst,
	input logic i_busy,
	input logic i_done,
	input logic i_error,
	input logic i_fram_wren,
	input logic i_fram_rden,
	input logic i_fram_rdy,
	input logic i_cudb_wren
);

	a_done_err: assert property (@(posedge clk) disable iff (rst) !(i_done && i_error))
		else $error("done and error pulsed in the same cycle");

	// no FRAM operation while the controller is busy
	a_fram_rdy: assert property (@(posedge clk) disable iff (rst)
		(i_fram_wren || i_fram_rden) |-> i_fram_rdy)
		else $error("FRAM strobe issued while ready is low");

	a_cudb_busy: assert property (@(posedge clk) disable iff (rst) i_cudb_wren |-> i_busy)
		else $error("result RAM written while the engine is idle");

endmodule

bind area_scan_io area_scan_chk area_scan_chk_i (
	.clk(clk), .rst(rst), .i_busy(o_busy), .i_done(o_done), .i_error(o_error),
	.i_fram_wren(o_fram_wren), .i_fram_rden(o_fram_rden), .i_fram_rdy(i_fram_rdy),
	.i_cudb_wren(o_cudb_wren)
);

// ==== area_scan_io.sv ====
`timescale 1ns/10ps
// ========================================
// area scan engine
// copies one area into the buffer, then
// walks its records through the FRAM and
// writes verified results
// ========================================
module area_scan_io (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      i_start,
	input  area_scan_pkg::base_addr_t i_base_addr,
	output logic                      o_busy,
	output logic                      o_done,
	output logic                      o_error,
	output area_scan_pkg::cddb_addr_t o_cddb_addr,
	input  area_scan_pkg::byte_t      i_cddb_rdata,
	output logic                      o_buf_wren,
	output area_scan_pkg::buf_addr_t  o_buf_waddr,
	output area_scan_pkg::byte_t      o_buf_wdata,
	output area_scan_pkg::buf_addr_t  o_buf_raddr,
	input  area_scan_pkg::byte_t      i_buf_rdata,
	output logic                      o_cudb_wren,
	output area_scan_pkg::cddb_addr_t o_cudb_addr,
	output area_scan_pkg::byte_t      o_cudb_din,
	output logic                      o_fram_wren,
	output logic                      o_fram_rden,
	output logic [15:0]               o_fram_wr_len,
	output area_scan_pkg::fram_addr_t o_fram_addr,
	output logic                      o_fram_wr_dv,
	output area_scan_pkg::byte_t      o_fram_wdata,
	input  logic                      i_fram_rd_dv,
	input  area_scan_pkg::byte_t      i_fram_rdata,
	input  logic                      i_fram_rdy
);
	import area_scan_pkg::*;

	scan_state_t state;
	cddb_addr_t  base_byte;
	cddb_addr_t  rec_addr;
	logic [7:0]  fill_cnt;
	logic [5:0]  rec_idx;
	logic        byte_sel;
	logic [9:0]  wait_cnt;
	byte_t       data_r;
	byte_t       cmd_r;
	logic [15:0] rd_buf;
	logic [3:0]  data_cs;
	logic [3:0]  rd_cs;

	function automatic logic [3:0] popcount(input byte_t b);
		logic [3:0] n;
		n = 4'd0;
		for (int i = 0; i < 8; i++) begin
			n = n + 4'(b[i]);
		end
		return n;
	endfunction

	assign o_busy      = (state != ST_IDLE);
	assign rec_addr    = base_byte + cddb_addr_t'(rec_idx * REC_BYTES);
	assign o_buf_raddr = buf_addr_t'(rec_idx * REC_BYTES) + buf_addr_t'(byte_sel);
	assign data_cs     = popcount(data_r);
	assign rd_cs       = popcount(rd_buf[15:8]);

	// ========================================
	// fill, command RAM to buffer
	// ========================================
	// read data trails the address by one cycle, the write by two
	always_ff @(posedge clk) begin
		if (rst) begin
			o_buf_wren <= 1'b0;
		end else begin
			o_buf_wren <= (state == ST_FILL) && (fill_cnt != 8'd0)
				&& (fill_cnt <= 8'(AREA_LEN));
		end
	end

	always_ff @(posedge clk) begin
		o_buf_waddr <= buf_addr_t'(fill_cnt - 8'd1);
		o_buf_wdata <= i_cddb_rdata;
	end

	// ========================================
	// record FSM
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= ST_IDLE;
			base_byte     <= '0;
			o_cddb_addr   <= '0;
			fill_cnt      <= '0;
			rec_idx       <= '0;
			byte_sel      <= 1'b0;
			wait_cnt      <= '0;
			o_done        <= 1'b0;
			o_error       <= 1'b0;
			o_fram_wren   <= 1'b0;
			o_fram_rden   <= 1'b0;
			o_fram_wr_dv  <= 1'b0;
			o_fram_wr_len <= '0;
			o_fram_addr   <= '0;
			o_cudb_wren   <= 1'b0;
		end else begin
			o_done      <= 1'b0;
			o_error     <= 1'b0;
			o_fram_wren <= 1'b0;
			o_fram_rden <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						base_byte   <= {i_base_addr, 4'd0};
						o_cddb_addr <= {i_base_addr, 4'd0};
						fill_cnt    <= '0;
						state       <= ST_FILL;
					end
				end
				ST_FILL: begin
					o_cddb_addr <= o_cddb_addr + 1'b1;
					fill_cnt    <= fill_cnt + 8'd1;
					if (fill_cnt == 8'(AREA_LEN + 1)) begin
						rec_idx  <= '0;
						byte_sel <= 1'b0;
						state    <= ST_LOAD;
					end
				end
				// data byte arrives while the command byte is addressed
				ST_LOAD: begin
					if (!byte_sel) begin
						byte_sel <= 1'b1;
					end else begin
						data_r <= i_buf_rdata;
						state  <= ST_WAIT_BUF;
					end
				end
				ST_WAIT_BUF: begin
					cmd_r    <= i_buf_rdata;
					byte_sel <= 1'b0;
					state    <= ST_DECODE;
				end
				ST_DECODE: begin
					o_fram_addr <= fram_addr_t'(rec_addr);
					wait_cnt    <= '0;
					if (cmd_r[3:0] == OP_SAVE) begin
						o_fram_wren   <= 1'b1;
						o_fram_wr_len <= 16'(REC_BYTES);
						state         <= ST_WR_DATA;
					end else if (cmd_r[3:0] == OP_REQ) begin
						state <= ST_WAIT_RDY;
					end else begin
						state <= ST_FAIL;
					end
				end
				ST_WR_DATA: begin
					o_fram_wr_dv <= 1'b1;
					o_fram_wdata <= data_r;
					state        <= ST_WR_CS;
				end
				ST_WR_CS: begin
					o_fram_wdata <= {data_cs, 4'd0};
					state        <= ST_WAIT_RDY;
				end
				ST_WAIT_RDY: begin
					o_fram_wr_dv <= 1'b0;
					if (i_fram_rdy) begin
						o_fram_rden <= 1'b1;
						state       <= ST_READ;
					end else if (wait_cnt == 10'(FRAM_TIMEOUT - 1)) begin
						state <= ST_FAIL;
					end else begin
						wait_cnt <= wait_cnt + 10'd1;
					end
				end
				ST_READ: begin
					if (i_fram_rd_dv) begin
						rd_buf   <= {rd_buf[7:0], i_fram_rdata};
						byte_sel <= ~byte_sel;
						if (byte_sel) begin
							state <= ST_VERIFY;
						end
					end
				end
				// checksum nibble sits in the high half of the second byte
				ST_VERIFY: begin
					if (rd_buf[7:4] == rd_cs) begin
						o_cudb_wren <= 1'b1;
						o_cudb_addr <= rec_addr;
						o_cudb_din  <= rd_buf[15:8];
						state       <= ST_STORE_DATA;
					end else begin
						state <= ST_FAIL;
					end
				end
				ST_STORE_DATA: begin
					o_cudb_addr <= o_cudb_addr + 1'b1;
					o_cudb_din  <= cmd_r;
					state       <= ST_STORE_CMD;
				end
				ST_STORE_CMD: begin
					o_cudb_wren <= 1'b0;
					if (rec_idx == 6'(REC_COUNT - 1)) begin
						o_done <= 1'b1;
						state  <= ST_IDLE;
					end else begin
						rec_idx <= rec_idx + 6'd1;
						state   <= ST_LOAD;
					end
				end
				ST_FAIL: begin
					o_error <= 1'b1;
					state   <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== area_scan_pkg.sv ====
// ========================================
// area scan shared definitions
// widths, opcodes, bus map and engine states
// ========================================
package area_scan_pkg;

	localparam int CDDB_AW       = 13;
	localparam int BUF_AW        = 11;
	localparam int BASE_W        = 9;
	localparam int FRAM_AW       = 16;
	localparam int FRAM_STORE_AW = 13;

	typedef logic [CDDB_AW-1:0] cddb_addr_t;
	typedef logic [BUF_AW-1:0]  buf_addr_t;
	typedef logic [BASE_W-1:0]  base_addr_t;
	typedef logic [FRAM_AW-1:0] fram_addr_t;
	typedef logic [7:0]         byte_t;

	// area layout, data byte then command byte
	localparam int AREA_LEN  = 128;
	localparam int REC_BYTES = 2;
	localparam int REC_COUNT = AREA_LEN / REC_BYTES;

	localparam logic [3:0] OP_SAVE = 4'h4;
	localparam logic [3:0] OP_REQ  = 4'h0;

	// fram timing in clock cycles
	localparam int FRAM_TIMEOUT   = 1000;
	localparam int FRAM_WR_CYCLES = 24;
	localparam int FRAM_RD_DELAY  = 2;

	// wishbone word address map
	localparam logic [15:0] WB_CDDB_BASE = 16'h0000;
	localparam logic [15:0] WB_CUDB_BASE = 16'h4000;
	localparam logic [15:0] REG_CTRL     = 16'h8000;
	localparam logic [15:0] REG_BASE_LO  = 16'h8001;
	localparam logic [15:0] REG_BASE_HI  = 16'h8002;
	localparam logic [15:0] REG_STATUS   = 16'h8003;

	typedef enum logic [3:0] {
		ST_IDLE, ST_FILL, ST_LOAD, ST_WAIT_BUF, ST_DECODE, ST_WR_DATA, ST_WR_CS,
		ST_WAIT_RDY, ST_READ, ST_VERIFY, ST_STORE_DATA, ST_STORE_CMD, ST_FAIL
	} scan_state_t;

endpackage

// ==== area_scan_top.f ====
area_scan_pkg.sv
dp_ram.sv
fram_ctrl.sv
area_scan_io.sv
scan_wb_regs.sv
area_scan_top.sv
area_scan_chk.sv
tb_area_scan.sv

// ==== area_scan_top.sv ====
`timescale 1ns/10ps
// ========================================
// area scan subsystem top
// bus slave, scan engine, FRAM and RAMs
// ========================================
module area_scan_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 i_wb_cyc,
	input  logic                 i_wb_stb,
	input  logic                 i_wb_we,
	input  logic [15:0]          i_wb_adr,
	input  area_scan_pkg::byte_t i_wb_dat,
	output area_scan_pkg::byte_t o_wb_dat,
	output logic                 o_wb_ack
);
	import area_scan_pkg::*;

	logic        cddb_wren, buf_wren, cudb_wren;
	cddb_addr_t  cddb_waddr, cddb_raddr, cudb_waddr, cudb_raddr;
	buf_addr_t   buf_waddr, buf_raddr;
	byte_t       cddb_wdata, cddb_rdata, buf_wdata, buf_rdata, cudb_wdata, cudb_rdata;
	logic        start, busy, done, error;
	base_addr_t  base_addr;
	logic        fram_wren, fram_rden, fram_wr_dv, fram_rd_dv, fram_rdy;
	logic [15:0] fram_wr_len;
	fram_addr_t  fram_addr;
	byte_t       fram_wdata, fram_rdata;

	scan_wb_regs scan_wb_regs_i (
		.clk(clk), .rst(rst),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
		.o_cddb_wren(cddb_wren), .o_cddb_addr(cddb_waddr), .o_cddb_wdata(cddb_wdata),
		.o_cudb_addr(cudb_raddr), .i_cudb_rdata(cudb_rdata),
		.o_start(start), .o_base_addr(base_addr),
		.i_busy(busy), .i_done(done), .i_error(error)
	);

	area_scan_io area_scan_io_i (
		.clk(clk), .rst(rst),
		.i_start(start), .i_base_addr(base_addr),
		.o_busy(busy), .o_done(done), .o_error(error),
		.o_cddb_addr(cddb_raddr), .i_cddb_rdata(cddb_rdata),
		.o_buf_wren(buf_wren), .o_buf_waddr(buf_waddr), .o_buf_wdata(buf_wdata),
		.o_buf_raddr(buf_raddr), .i_buf_rdata(buf_rdata),
		.o_cudb_wren(cudb_wren), .o_cudb_addr(cudb_waddr), .o_cudb_din(cudb_wdata),
		.o_fram_wren(fram_wren), .o_fram_rden(fram_rden), .o_fram_wr_len(fram_wr_len),
		.o_fram_addr(fram_addr), .o_fram_wr_dv(fram_wr_dv), .o_fram_wdata(fram_wdata),
		.i_fram_rd_dv(fram_rd_dv), .i_fram_rdata(fram_rdata), .i_fram_rdy(fram_rdy)
	);

	fram_ctrl fram_ctrl_i (
		.clk(clk), .rst(rst),
		.i_wren(fram_wren), .i_rden(fram_rden), .i_wr_len(fram_wr_len), .i_addr(fram_addr),
		.i_wr_dv(fram_wr_dv), .i_wdata(fram_wdata),
		.o_rd_dv(fram_rd_dv), .o_rdata(fram_rdata), .o_rdy(fram_rdy)
	);

	// command area loaded by the host
	dp_ram #(.ADDR_W(CDDB_AW)) cddb_ram (
		.clk(clk), .i_wren(cddb_wren), .i_waddr(cddb_waddr), .i_wdata(cddb_wdata),
		.i_raddr(cddb_raddr), .o_rdata(cddb_rdata)
	);

	dp_ram #(.ADDR_W(BUF_AW)) buf_ram (
		.clk(clk), .i_wren(buf_wren), .i_waddr(buf_waddr), .i_wdata(buf_wdata),
		.i_raddr(buf_raddr), .o_rdata(buf_rdata)
	);

	// results read back by the host
	dp_ram #(.ADDR_W(CDDB_AW)) cudb_ram (
		.clk(clk), .i_wren(cudb_wren), .i_waddr(cudb_waddr), .i_wdata(cudb_wdata),
		.i_raddr(cudb_raddr), .o_rdata(cudb_rdata)
	);

endmodule

// ==== dp_ram.sv ====
`timescale 1ns/10ps
// ========================================
// byte RAM, one write port and one
// registered read port, write-first
// ========================================
module dp_ram #(
	parameter int ADDR_W = 13
) (
	input  logic                 clk,
	input  logic                 i_wren,
	input  logic [ADDR_W-1:0]    i_waddr,
	input  area_scan_pkg::byte_t i_wdata,
	input  logic [ADDR_W-1:0]    i_raddr,
	output area_scan_pkg::byte_t o_rdata
);
	import area_scan_pkg::*;

	byte_t mem [2**ADDR_W];

	always_ff @(posedge clk) begin
		if (i_wren) begin
			mem[i_waddr] <= i_wdata;
		end
		// same-address write is passed straight to the read port
		if (i_wren && (i_waddr == i_raddr)) begin
			o_rdata <= i_wdata;
		end else begin
			o_rdata <= mem[i_raddr];
		end
	end

endmodule

// ==== fram_ctrl.sv ====
`timescale 1ns/10ps
// ========================================
// on-chip FRAM controller
// burst writes with a busy period after,
// two-byte reads after a fixed delay
// ========================================
module fram_ctrl (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      i_wren,
	input  logic                      i_rden,
	input  logic [15:0]               i_wr_len,
	input  area_scan_pkg::fram_addr_t i_addr,
	input  logic                      i_wr_dv,
	input  area_scan_pkg::byte_t      i_wdata,
	output logic                      o_rd_dv,
	output area_scan_pkg::byte_t      o_rdata,
	output logic                      o_rdy
);
	import area_scan_pkg::*;

	typedef enum logic [1:0] {F_IDLE, F_WRITE, F_BUSY, F_READ} fram_state_t;

	fram_state_t              state;
	byte_t                    mem [2**FRAM_STORE_AW];
	logic [FRAM_STORE_AW-1:0] ptr;
	logic [15:0]              remain;
	logic [15:0]              cnt;
	logic                     rd_emit;

	// erased cells read as all ones
	initial begin
		for (int i = 0; i < 2**FRAM_STORE_AW; i++) begin
			mem[i] = 8'hFF;
		end
	end

	assign o_rdy = (state == F_IDLE);
	// output register adds the last cycle of the read delay
	assign rd_emit = (state == F_READ) && ((cnt + 16'd2) >= 16'(FRAM_RD_DELAY));

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= F_IDLE;
			ptr     <= '0;
			remain  <= '0;
			cnt     <= '0;
			o_rd_dv <= 1'b0;
		end else begin
			o_rd_dv <= rd_emit;
			case (state)
				F_IDLE: begin
					cnt <= '0;
					if (i_wren) begin
						ptr    <= i_addr[FRAM_STORE_AW-1:0];
						remain <= i_wr_len;
						state  <= (i_wr_len == 16'd0) ? F_BUSY : F_WRITE;
					end else if (i_rden) begin
						ptr   <= i_addr[FRAM_STORE_AW-1:0];
						state <= F_READ;
					end
				end
				F_WRITE: begin
					if (i_wr_dv) begin
						ptr    <= ptr + 1'b1;
						remain <= remain - 16'd1;
						if (remain == 16'd1) begin
							state <= F_BUSY;
						end
					end
				end
				F_BUSY: begin
					if (cnt == 16'(FRAM_WR_CYCLES - 1)) begin
						state <= F_IDLE;
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				F_READ: begin
					cnt <= cnt + 16'd1;
					if (rd_emit) begin
						ptr <= ptr + 1'b1;
					end
					if (cnt == 16'(FRAM_RD_DELAY - 1)) begin
						state <= F_IDLE;
					end
				end
				default: state <= F_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == F_WRITE) && i_wr_dv) begin
			mem[ptr] <= i_wdata;
		end
		if (rd_emit) begin
			o_rdata <= mem[ptr];
		end
	end

endmodule

// ==== scan_wb_regs.sv ====
`timescale 1ns/10ps
// ========================================
// wishbone classic slave
// command RAM and result RAM windows,
// control, base and status registers
// ========================================
module scan_wb_regs (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      i_wb_cyc,
	input  logic                      i_wb_stb,
	input  logic                      i_wb_we,
	input  logic [15:0]               i_wb_adr,
	input  area_scan_pkg::byte_t      i_wb_dat,
	output area_scan_pkg::byte_t      o_wb_dat,
	output logic                      o_wb_ack,
	output logic                      o_cddb_wren,
	output area_scan_pkg::cddb_addr_t o_cddb_addr,
	output area_scan_pkg::byte_t      o_cddb_wdata,
	output area_scan_pkg::cddb_addr_t o_cudb_addr,
	input  area_scan_pkg::byte_t      i_cudb_rdata,
	output logic                      o_start,
	output area_scan_pkg::base_addr_t o_base_addr,
	input  logic                      i_busy,
	input  logic                      i_done,
	input  logic                      i_error
);
	import area_scan_pkg::*;

	logic  req;
	logic  req_wr;
	logic  req_rd;
	logic  in_cddb;
	logic  in_cudb;
	logic  cudb_sel;
	logic  done_r;
	logic  error_r;
	byte_t reg_rdata;

	// no new request in the ack cycle, so a held request gets a gap
	assign req     = i_wb_cyc & i_wb_stb & ~o_wb_ack;
	assign req_wr  = req & i_wb_we;
	assign req_rd  = req & ~i_wb_we;
	assign in_cddb = (i_wb_adr[15:13] == WB_CDDB_BASE[15:13]);
	assign in_cudb = (i_wb_adr[15:13] == WB_CUDB_BASE[15:13]);

	assign o_cddb_wren  = req_wr & in_cddb;
	assign o_cddb_addr  = cddb_addr_t'(i_wb_adr);
	assign o_cddb_wdata = i_wb_dat;
	assign o_cudb_addr  = cddb_addr_t'(i_wb_adr);
	assign o_wb_dat     = cudb_sel ? i_cudb_rdata : reg_rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			o_wb_ack    <= 1'b0;
			o_start     <= 1'b0;
			o_base_addr <= '0;
			cudb_sel    <= 1'b0;
			done_r      <= 1'b0;
			error_r     <= 1'b0;
		end else begin
			o_wb_ack <= req;
			o_start  <= 1'b0;
			if (req_rd) begin
				cudb_sel <= in_cudb;
			end
			// start clears the sticky bits of the last scan
			if (req_wr && (i_wb_adr == REG_CTRL) && i_wb_dat[0] && !i_busy) begin
				o_start <= 1'b1;
				done_r  <= 1'b0;
				error_r <= 1'b0;
			end else begin
				done_r  <= done_r | i_done;
				error_r <= error_r | i_error;
			end
			if (req_wr && (i_wb_adr == REG_BASE_LO)) begin
				o_base_addr[7:0] <= i_wb_dat;
			end
			if (req_wr && (i_wb_adr == REG_BASE_HI)) begin
				o_base_addr[8] <= i_wb_dat[0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_rd) begin
			case (i_wb_adr)
				REG_BASE_LO: reg_rdata <= o_base_addr[7:0];
				REG_BASE_HI: reg_rdata <= {7'd0, o_base_addr[8]};
				// the end pulse comes in the same cycle that busy falls
				REG_STATUS:  reg_rdata <= {5'd0, error_r | i_error, done_r | i_done, i_busy};
				default:     reg_rdata <= 8'd0;
			endcase
		end
	end

endmodule

// ==== tb_area_scan.sv ====
`timescale 1ns/10ps
// ========================================
// area scan testbench
// loads areas over wishbone, runs scans and
// checks results against a reference model
// ========================================
module tb_area_scan;
	import area_scan_pkg::*;

	localparam int WB_TIMEOUT   = 50;
	localparam int POLL_TIMEOUT = 200000;
	localparam int K_SAVE = 0;
	localparam int K_REQ  = 1;
	localparam int K_BAD  = 2;
	localparam int N_ROWS = 5;

	logic        clk;
	logic        rst;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [15:0] wb_adr;
	byte_t       wb_dat;
	byte_t       wb_rdat;
	logic        wb_ack;

	// test table, one row per scan
	string      t_name [N_ROWS] = '{"save", "request", "blank", "bad_op", "double_start"};
	base_addr_t t_base [N_ROWS] = '{9'h012, 9'h012, 9'h140, 9'h0A3, 9'h1FF};
	int         t_kind [N_ROWS] = '{K_SAVE, K_REQ, K_REQ, K_BAD, K_SAVE};
	int         t_bad  [N_ROWS] = '{0, 0, 0, 17, 0};
	logic       t_dbl  [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
	logic       t_err  [N_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0};

	// reference model state
	byte_t       fram_m [8192];
	byte_t       cudb_m [8192];
	logic        known [8192];
	byte_t       area [AREA_LEN];
	logic [31:0] lfsr_state = 32'h766d_427f;
	int          cycles = 0;
	int          errors = 0;
	int          failed = 0;
	logic        hung = 1'b0;

	area_scan_top area_scan_top_i (
		.clk(clk), .rst(rst), .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
		.i_wb_adr(wb_adr), .i_wb_dat(wb_dat), .o_wb_dat(wb_rdat), .o_wb_ack(wb_ack)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output byte_t v);
		v = 8'h00;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [3:0] count_ones(input byte_t b);
		logic [3:0] n;
		byte_t      v;
		n = 4'd0;
		v = b;
		while (v != 8'h00) begin
			n = n + 4'd1;
			v = v & (v - 8'h01);
		end
		return n;
	endfunction

	task automatic check_val(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// ========================================
	// wishbone host
	// ========================================
	task automatic wb_cycle(input logic we, input logic [15:0] adr, input byte_t wdat,
			output byte_t rdat);
		int   n;
		logic got;
		rdat = 8'h00;
		n = 0;
		got = 1'b0;
		if (!hung) begin
			@(posedge clk);
			wb_cyc <= 1'b1;
			wb_stb <= 1'b1;
			wb_we  <= we;
			wb_adr <= adr;
			wb_dat <= wdat;
			while (!got && n < WB_TIMEOUT) begin
				@(negedge clk);
				if ($isunknown(wb_ack)) begin
					$display("ack is unknown at address %h", adr);
					errors++;
				end
				if (wb_ack === 1'b1) begin
					got = 1'b1;
					rdat = wb_rdat;
				end
				n++;
			end
			@(posedge clk);
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we  <= 1'b0;
			if (!got) begin
				$display("no wishbone ack for address %h", adr);
				errors++;
				hung = 1'b1;
			end
		end
	endtask

	task automatic wb_write(input logic [15:0] adr, input byte_t dat);
		byte_t unused;
		wb_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [15:0] adr, output byte_t dat);
		wb_cycle(1'b0, adr, 8'h00, dat);
	endtask

	// poll status until busy falls
	task automatic wait_idle(output byte_t st);
		int start_cyc;
		start_cyc = cycles;
		st = 8'h01;
		while (st[0] !== 1'b0 && !hung) begin
			if (cycles - start_cyc > POLL_TIMEOUT) begin
				$display("scan did not finish within %0d cycles", POLL_TIMEOUT);
				errors++;
				hung = 1'b1;
			end else begin
				wb_read(REG_STATUS, st);
			end
		end
	endtask

	// ========================================
	// reference model and test flow
	// ========================================
	task automatic model_scan(input cddb_addr_t base16, output logic err);
		cddb_addr_t a;
		byte_t      d;
		byte_t      c;
		err = 1'b0;
		for (int k = 0; k < REC_COUNT && !err; k++) begin
			a = base16 + 13'(2 * k);
			c = area[2 * k + 1];
			if (c[3:0] != OP_SAVE && c[3:0] != OP_REQ) begin
				err = 1'b1;
			end else begin
				if (c[3:0] == OP_SAVE) begin
					fram_m[a] = area[2 * k];
					fram_m[a + 13'd1] = {count_ones(area[2 * k]), 4'h0};
				end
				d = fram_m[a];
				if (fram_m[a + 13'd1][7:4] != count_ones(d)) begin
					err = 1'b1;
				end else begin
					cudb_m[a] = d;
					cudb_m[a + 13'd1] = c;
					known[a] = 1'b1;
					known[a + 13'd1] = 1'b1;
				end
			end
		end
	endtask

	task automatic check_results(input cddb_addr_t base16);
		cddb_addr_t a;
		byte_t      v;
		for (int i = 0; i < AREA_LEN; i++) begin
			a = base16 + 13'(i);
			wb_read({3'b010, a}, v);
			check_val($sformatf("result[%h]", a), v, cudb_m[a]);
		end
	endtask

	task automatic run_row(input int t);
		cddb_addr_t base16;
		cddb_addr_t a;
		byte_t      d;
		byte_t      hi;
		byte_t      st;
		logic       err;
		base16 = {t_base[t], 4'd0};
		for (int k = 0; k < REC_COUNT; k++) begin
			rand_bits(8, d);
			rand_bits(4, hi);
			area[2 * k] = d;
			area[2 * k + 1] = {hi[3:0], (t_kind[t] == K_REQ) ? OP_REQ : OP_SAVE};
			if (t_kind[t] == K_BAD && k == t_bad[t]) begin
				area[2 * k + 1][3:0] = 4'h9;
			end
		end
		for (int i = 0; i < AREA_LEN; i++) begin
			a = base16 + 13'(i);
			wb_write({3'b000, a}, area[i]);
			// untouched result bytes must keep their current value
			if (!known[a]) begin
				wb_read({3'b010, a}, cudb_m[a]);
			end
		end
		model_scan(base16, err);
		if (err !== t_err[t]) begin
			$display("model outcome differs from the table in row %s", t_name[t]);
			errors++;
		end
		wb_write(REG_BASE_LO, t_base[t][7:0]);
		wb_write(REG_BASE_HI, {7'd0, t_base[t][8]});
		wb_write(REG_CTRL, 8'h01);
		if (t_dbl[t]) begin
			wb_write(REG_CTRL, 8'h01);
		end
		wait_idle(st);
		check_val("status", st, err ? 8'h04 : 8'h02);
		// a second start would show busy again here
		wb_read(REG_STATUS, st);
		check_val("status", st, err ? 8'h04 : 8'h02);
		check_results(base16);
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: FAILED with %0d errors", name, errors - errs_before);
		end
	endtask

	initial begin
		byte_t st;
		int    errs_before;
		clk = 1'b0;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 16'h0000;
		wb_dat = 8'h00;
		for (int i = 0; i < 8192; i++) begin
			fram_m[i] = 8'hFF;
			known[i] = 1'b0;
		end
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		errs_before = errors;
		wb_read(REG_STATUS, st);
		check_val("status", st, 8'h00);
		end_test("reset_status", errs_before);

		for (int t = 0; t < N_ROWS && !hung; t++) begin
			errs_before = errors;
			run_row(t);
			end_test(t_name[t], errs_before);
		end

		// results survive a reset
		errs_before = errors;
		@(posedge clk);
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		wb_read(REG_STATUS, st);
		check_val("status", st, 8'h00);
		check_results({t_base[1], 4'd0});
		end_test("reset_retention", errs_before);

		$display("%0d tests run, %0d failed, %0d errors", N_ROWS + 2, failed, errors);
		if (errors == 0 && !hung) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
